/* compile.f */
+incdir+include
design/am_lock_pkg.sv
design/am_compare.sv
design/am_lock_fsm.sv
design/am_marker_strip.sv
design/am_wb_regs.sv
design/am_lock_top.sv
sim/am_lock_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the alignment marker lock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module am_lock_tb \
	-o am_lock_sim

./obj_dir/am_lock_sim | tee sim.log

# the log decides, the simulator status alone is not enough
if grep -q "Simulation passed" sim.log
then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi

/* sim/am_lock_tb.sv */
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		am_lock_pkg::lane_idx_t lane;
		am_lock_pkg::thr_t lock_thr;
		am_lock_pkg::thr_t unlock_thr;
		int good;	// confirmed periods after the first marker
		int missed;
		logic alt;	// good period after every miss
		logic exp_lock;
		am_lock_pkg::lane_idx_t exp_lane;
	} row_s;

	typedef struct packed {
		am_lock_pkg::block_t blk;
		logic am_flag;
		logic lock;
		logic [31:0] cyc;	// input cycle, for the latency check
	} exp_s;

	localparam int N_ROWS = 6;
	localparam row_s ROWS [N_ROWS] = '{
		// lane, lock, unlock, good, missed, alt, exp lock, exp lane
		'{2'd0, 4'd3, 4'd2, 3, 0, 1'b0, 1'b1, 2'd0},
		'{2'd1, 4'd3, 4'd2, 2, 0, 1'b0, 1'b0, 2'd1},
		'{2'd2, 4'd2, 4'd3, 3, 2, 1'b0, 1'b1, 2'd2},
		'{2'd3, 4'd2, 4'd2, 2, 2, 1'b0, 1'b0, 2'd3},
		'{2'd1, 4'd1, 4'd2, 2, 3, 1'b1, 1'b1, 2'd1},
		'{2'd2, 4'd4, 4'd1, 5, 1, 1'b0, 1'b0, 2'd2}
	};

	logic i_clock = 1'b0;
	logic i_arst_n;
	logic i_block_lock;
	am_lock_pkg::blk_stream_s i_block;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [`AM_WB_ADR_W-1:0] i_wb_adr;
	am_lock_pkg::wb_data_t i_wb_dat;
	am_lock_pkg::wb_data_t o_wb_dat;
	logic o_wb_ack;
	am_lock_pkg::blk_stream_s o_block;
	logic o_am_flag;
	logic o_lock;
	am_lock_pkg::lane_idx_t o_lane_idx;
	logic o_lane_valid;

	integer seed = 32'h978f_bb92;
	int cycle_cnt = 0;
	int cycle_limit = 1000;
	logic mon_en = 1'b0;
	exp_s exp_q [$];
	int phase;	// 0 search, 1 confirm, 2 locked
	int good_cnt;
	int bad_cnt;

	am_lock_top u_am_lock_top (
		.i_clock (i_clock),
		.i_arst_n (i_arst_n),
		.i_block_lock (i_block_lock),
		.i_block (i_block),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.o_block (o_block),
		.o_am_flag (o_am_flag),
		.o_lock (o_lock),
		.o_lane_idx (o_lane_idx),
		.o_lane_valid (o_lane_valid)
	);

	always #20 i_clock = ~i_clock;

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic int timeout_limit();
		int total;
		total = 16 + 64;	// reset and first register checks
		for (int r = 0; r < N_ROWS; r++)
			total += (ROWS[r].good + ROWS[r].missed * (ROWS[r].alt ? 2 : 1) + 2)
				* `AM_SPACING * 2 + 48;
		return total;
	endfunction

	always @(posedge i_clock)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			stop_on_error($sformatf("timeout after %0d cycles", cycle_limit));
	end

	task automatic next_cycle();
		@(posedge i_clock);
		#2;
	endtask

	function automatic am_lock_pkg::block_t random_block();
		am_lock_pkg::block_t b;
		b.sync = `AM_SYNC_DATA;
		b.payload = {$random(seed), $random(seed)};
		return b;
	endfunction

	function automatic am_lock_pkg::block_t marker_block(input am_lock_pkg::lane_idx_t lane);
		am_lock_pkg::block_t b;
		b.sync = `AM_SYNC_CTRL;
		case (lane)
			2'd0: b.payload = `AM_PATTERN_0;
			2'd1: b.payload = `AM_PATTERN_1;
			2'd2: b.payload = `AM_PATTERN_2;
			2'd3: b.payload = `AM_PATTERN_3;
		endcase
		return b;
	endfunction

	// one access, stb held one cycle past ack
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		next_cycle();
		waited = 1;
		while (!o_wb_ack && waited < 4)
		begin
			next_cycle();
			waited++;
		end
		if (!o_wb_ack)
			stop_on_error("wishbone slave gave no ack within 4 cycles");
		compare_value("wb_ack_delay", 128'(waited), 128'(1));
		rdat = o_wb_dat;
		next_cycle();
		compare_value("o_wb_ack", 128'(o_wb_ack), 128'(0));
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
	endtask

	// lock rule, applied at each expected marker position
	task automatic update_model(input row_s r, input logic marker);
		if (marker)
		begin
			if (phase == 0)
			begin
				phase = 1;
				good_cnt = 0;
			end
			else if (phase == 1)
			begin
				good_cnt++;
				if (good_cnt >= int'(r.lock_thr))
				begin
					phase = 2;
					bad_cnt = 0;
				end
			end
			else
				bad_cnt = 0;
		end
		else if (phase == 1)
			phase = 0;
		else if (phase == 2)
		begin
			bad_cnt++;
			if (bad_cnt >= int'(r.unlock_thr))
				phase = 0;
		end
	endtask

	task automatic send_period(input row_s r, input logic marker);
		exp_s e;
		for (int n = 1; n <= `AM_SPACING; n++)
		begin
			while (($random(seed) & 3) == 0)	// roughly one bubble in four
			begin
				i_block.valid = 1'b0;
				i_block.blk = random_block();
				next_cycle();
			end
			i_block.valid = 1'b1;
			i_block.blk = (n == `AM_SPACING && marker) ? marker_block(r.lane) : random_block();
			if (n == `AM_SPACING)
				update_model(r, marker);
			e.blk = i_block.blk;
			e.lock = (phase == 2);
			e.am_flag = marker && (n == `AM_SPACING) && (phase == 2);
			e.cyc = cycle_cnt;
			exp_q.push_back(e);
			next_cycle();
		end
	endtask

	task automatic check_output();
		exp_s e;
		if (o_block.valid)
		begin
			if (exp_q.size() == 0)
				stop_on_error("valid output block with no input block pending");
			e = exp_q.pop_front();
			compare_value("o_block", 128'(o_block.blk), 128'(e.blk));
			compare_value("latency", 128'(cycle_cnt - e.cyc), 128'(3));
			compare_value("o_am_flag", 128'(o_am_flag), 128'(e.am_flag));
			compare_value("o_lock", 128'(o_lock), 128'(e.lock));
		end
		else
			compare_value("o_am_flag", 128'(o_am_flag), 128'(0));
	endtask

	always @(posedge i_clock)
	begin
		#1;	// outputs settled, inputs not yet driven
		if (mon_en)
			check_output();
	end

	task automatic run_row(input row_s r);
		logic [31:0] rd;
		i_block_lock = 1'b0;	// drops any lock of the previous row
		repeat (3) next_cycle();
		compare_value("o_lock", 128'(o_lock), 128'(0));
		compare_value("o_lane_valid", 128'(o_lane_valid), 128'(0));
		i_block_lock = 1'b1;
		wb_access(1'b1, `AM_REG_LOCK_THR, 32'(r.lock_thr), rd);
		wb_access(1'b1, `AM_REG_UNLOCK_THR, 32'(r.unlock_thr), rd);
		wb_access(1'b0, `AM_REG_LOCK_THR, '0, rd);
		compare_value("lock_thr", 128'(rd), 128'(r.lock_thr));
		wb_access(1'b0, `AM_REG_UNLOCK_THR, '0, rd);
		compare_value("unlock_thr", 128'(rd), 128'(r.unlock_thr));
		phase = 0;
		good_cnt = 0;
		bad_cnt = 0;
		send_period(r, 1'b1);	// first marker
		for (int i = 0; i < r.good; i++)
			send_period(r, 1'b1);
		for (int i = 0; i < r.missed; i++)
		begin
			send_period(r, 1'b0);
			if (r.alt)
				send_period(r, 1'b1);
		end
		i_block.valid = 1'b0;
		while (exp_q.size() != 0)
			next_cycle();
		compare_value("o_lock", 128'(o_lock), 128'(r.exp_lock));
		wb_access(1'b0, `AM_REG_STATUS, '0, rd);
		compare_value("status_upper", 128'(rd[31:4]), 128'(0));
		if (r.exp_lock)
		begin
			compare_value("o_lane_idx", 128'(o_lane_idx), 128'(r.exp_lane));
			compare_value("status", 128'(rd[3:0]), 128'({r.exp_lane, 2'b11}));
		end
		else
			compare_value("status", 128'(rd[1:0]), 128'(2'b00));
	endtask

	initial
	begin
		logic [31:0] rd;
		i_arst_n = 1'b0;
		i_block_lock = 1'b0;
		i_block = '0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		cycle_limit = timeout_limit();
		repeat (16) @(posedge i_clock);
		#2;
		i_arst_n = 1'b1;
		mon_en = 1'b1;
		wb_access(1'b1, `AM_REG_STATUS, 32'hF, rd);	// read only, thresholds keep reset values
		wb_access(1'b0, `AM_REG_LOCK_THR, '0, rd);
		compare_value("lock_thr_reset", 128'(rd), 128'(3));
		wb_access(1'b0, `AM_REG_UNLOCK_THR, '0, rd);
		compare_value("unlock_thr_reset", 128'(rd), 128'(2));
		wb_access(1'b0, `AM_REG_STATUS, '0, rd);
		compare_value("status_reset", 128'(rd), 128'(0));
		wb_access(1'b0, 2'd3, '0, rd);
		compare_value("unknown_adr", 128'(rd), 128'(0));
		for (int r = 0; r < N_ROWS; r++)
			run_row(ROWS[r]);
		i_block_lock = 1'b0;
		repeat (3) next_cycle();
		compare_value("o_lock", 128'(o_lock), 128'(0));
		compare_value("o_lane_valid", 128'(o_lane_valid), 128'(0));
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/am_lock_top.sv */
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_top
(
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_block_lock,
	input wire am_lock_pkg::blk_stream_s i_block,
	input wire logic i_wb_cyc,
	input wire logic i_wb_stb,
	input wire logic i_wb_we,
	input wire logic [`AM_WB_ADR_W-1:0] i_wb_adr,
	input wire am_lock_pkg::wb_data_t i_wb_dat,
	output am_lock_pkg::wb_data_t o_wb_dat,
	output logic o_wb_ack,
	output am_lock_pkg::blk_stream_s o_block,
	output logic o_am_flag,
	output logic o_lock,
	output am_lock_pkg::lane_idx_t o_lane_idx,
	output logic o_lane_valid
);

	wire am_lock_pkg::am_result_s result;
	wire am_lock_pkg::blk_stream_s fsm_block;
	wire am_lock_pkg::lock_ctl_s fsm_ctl;
	wire am_lock_pkg::thr_t lock_thr;
	wire am_lock_pkg::thr_t unlock_thr;

	am_compare u_am_compare (
		.i_clock (i_clock),
		.i_arst_n (i_arst_n),
		.i_block (i_block),
		.o_result (result)
	);

	am_lock_fsm u_am_lock_fsm (
		.i_clock (i_clock),
		.i_arst_n (i_arst_n),
		.i_block_lock (i_block_lock),
		.i_result (result),
		.i_lock_thr (lock_thr),
		.i_unlock_thr (unlock_thr),
		.o_block (fsm_block),
		.o_ctl (fsm_ctl)
	);

	am_marker_strip u_am_marker_strip (
		.i_clock (i_clock),
		.i_arst_n (i_arst_n),
		.i_block (fsm_block),
		.i_ctl (fsm_ctl),
		.o_block (o_block),
		.o_am_flag (o_am_flag),
		.o_lock (o_lock),
		.o_lane_idx (o_lane_idx),
		.o_lane_valid (o_lane_valid)
	);

	// status comes back from the output stage
	am_wb_regs u_am_wb_regs (
		.i_clock (i_clock),
		.i_arst_n (i_arst_n),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.i_lock (o_lock),
		.i_lane_valid (o_lane_valid),
		.i_lane_idx (o_lane_idx),
		.o_lock_thr (lock_thr),
		.o_unlock_thr (unlock_thr)
	);

endmodule

`default_nettype wire

/* design/am_wb_regs.sv */
`default_nettype none

`include "am_lock_cfg.svh"

module am_wb_regs
(
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_wb_cyc,
	input wire logic i_wb_stb,
	input wire logic i_wb_we,
	input wire logic [`AM_WB_ADR_W-1:0] i_wb_adr,
	input wire am_lock_pkg::wb_data_t i_wb_dat,
	output am_lock_pkg::wb_data_t o_wb_dat,
	output logic o_wb_ack,
	input wire logic i_lock,
	input wire logic i_lane_valid,
	input wire am_lock_pkg::lane_idx_t i_lane_idx,
	output am_lock_pkg::thr_t o_lock_thr,
	output am_lock_pkg::thr_t o_unlock_thr
);

	logic req;
	logic ack_q;
	am_lock_pkg::thr_t lock_thr_q;
	am_lock_pkg::thr_t unlock_thr_q;
	am_lock_pkg::wb_data_t rd_mux;
	am_lock_pkg::wb_data_t rd_q;

	// new request only while no ack is out
	assign req = i_wb_cyc && i_wb_stb && !ack_q;

	always_comb
	begin
		rd_mux = '0;	// unknown addresses read zero
		case (i_wb_adr)
			`AM_REG_LOCK_THR: rd_mux = am_lock_pkg::wb_data_t'(lock_thr_q);
			`AM_REG_UNLOCK_THR: rd_mux = am_lock_pkg::wb_data_t'(unlock_thr_q);
			`AM_REG_STATUS:
			begin
				rd_mux[0] = i_lock;
				rd_mux[1] = i_lane_valid;
				rd_mux[3:2] = i_lane_idx;
			end
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			ack_q <= 1'b0;
			lock_thr_q <= am_lock_pkg::thr_t'(`AM_LOCK_THR_RST);
			unlock_thr_q <= am_lock_pkg::thr_t'(`AM_UNLOCK_THR_RST);
		end
		else
		begin
			ack_q <= req;
			if (req && i_wb_we)
			begin
				// status is read only
				case (i_wb_adr)
					`AM_REG_LOCK_THR: lock_thr_q <= i_wb_dat[`AM_THR_W-1:0];
					`AM_REG_UNLOCK_THR: unlock_thr_q <= i_wb_dat[`AM_THR_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// read data lines up with ack
	always_ff @(posedge i_clock)
	begin
		rd_q <= (req && !i_wb_we) ? rd_mux : '0;
	end

	assign o_wb_ack = ack_q;
	assign o_wb_dat = rd_q;
	assign o_lock_thr = lock_thr_q;
	assign o_unlock_thr = unlock_thr_q;

endmodule

`default_nettype wire

/* design/am_marker_strip.sv */
`default_nettype none

`include "am_lock_cfg.svh"

module am_marker_strip
(
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire am_lock_pkg::blk_stream_s i_block,
	input wire am_lock_pkg::lock_ctl_s i_ctl,
	output am_lock_pkg::blk_stream_s o_block,
	output logic o_am_flag,
	output logic o_lock,
	output am_lock_pkg::lane_idx_t o_lane_idx,
	output logic o_lane_valid
);

	function automatic am_lock_pkg::lane_idx_t mask_to_idx(input am_lock_pkg::lane_mask_t mask);
		am_lock_pkg::lane_idx_t idx;
		idx = '0;
		for (int i = 0; i < `AM_N_LANES; i++)
		begin
			if (mask[i])
				idx = am_lock_pkg::lane_idx_t'(i);
		end
		return idx;
	endfunction

	logic valid_q;
	am_lock_pkg::block_t blk_q;

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			valid_q <= 1'b0;
			o_am_flag <= 1'b0;
			o_lock <= 1'b0;
			o_lane_idx <= '0;
			o_lane_valid <= 1'b0;
		end
		else
		begin
			valid_q <= i_block.valid;
			o_am_flag <= i_block.valid && i_ctl.am_pos && i_ctl.lock;	// marker to delete
			o_lock <= i_ctl.lock;
			o_lane_valid <= i_ctl.lock;
			if (i_ctl.lock)
				o_lane_idx <= mask_to_idx(i_ctl.mask);	// held while locked
		end
	end

	always_ff @(posedge i_clock)
	begin
		blk_q <= i_block.blk;
	end

	assign o_block.valid = valid_q;
	assign o_block.blk = blk_q;

endmodule

`default_nettype wire

/* design/am_lock_fsm.sv */
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_fsm
(
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire logic i_block_lock,
	input wire am_lock_pkg::am_result_s i_result,
	input wire am_lock_pkg::thr_t i_lock_thr,
	input wire am_lock_pkg::thr_t i_unlock_thr,
	output am_lock_pkg::blk_stream_s o_block,
	output am_lock_pkg::lock_ctl_s o_ctl
);

	am_lock_pkg::lock_state_e state_q;
	am_lock_pkg::lock_state_e state_d;
	am_lock_pkg::lane_mask_t mask_q;
	am_lock_pkg::lane_mask_t mask_d;
	am_lock_pkg::spacing_cnt_t timer_q;
	am_lock_pkg::spacing_cnt_t timer_d;
	am_lock_pkg::thr_t good_q;
	am_lock_pkg::thr_t good_d;
	am_lock_pkg::thr_t bad_q;
	am_lock_pkg::thr_t bad_d;
	am_lock_pkg::thr_t good_inc;
	am_lock_pkg::thr_t bad_inc;
	am_lock_pkg::lock_ctl_s ctl_q;
	am_lock_pkg::lock_ctl_s ctl_d;

	logic timer_done;
	logic lane_hit;
	logic am_pos;
	logic blk_valid_q;
	am_lock_pkg::block_t blk_q;

	assign timer_done = (timer_q == am_lock_pkg::spacing_cnt_t'(`AM_SPACING));
	assign lane_hit = |(i_result.match & mask_q);	// marker from the captured lane only

	// saturating increments
	assign good_inc = (good_q == '1) ? good_q : good_q + 1'b1;
	assign bad_inc = (bad_q == '1) ? bad_q : bad_q + 1'b1;

	always_comb
	begin
		state_d = state_q;
		mask_d = mask_q;
		good_d = good_q;
		bad_d = bad_q;
		timer_d = timer_done ? am_lock_pkg::spacing_cnt_t'(1) : timer_q + 1'b1;
		am_pos = 1'b0;

		case (state_q)
			am_lock_pkg::INIT:
			begin
				mask_d = '1;
				state_d = am_lock_pkg::WAIT_1ST;
			end

			am_lock_pkg::WAIT_1ST:
			begin
				if (i_result.is_am)
				begin
					mask_d = i_result.match;
					timer_d = am_lock_pkg::spacing_cnt_t'(1);	// marker is position 0
					good_d = '0;
					bad_d = '0;
					state_d = am_lock_pkg::WAIT_2ND;
				end
			end

			am_lock_pkg::WAIT_2ND:
			begin
				if (timer_done && lane_hit)
				begin
					am_pos = 1'b1;
					good_d = good_inc;
					if (good_inc >= i_lock_thr)
					begin
						bad_d = '0;
						state_d = am_lock_pkg::LOCKED;
					end
				end
				else if (timer_done)
				begin
					mask_d = '1;	// search all lanes again
					state_d = am_lock_pkg::WAIT_1ST;
				end
			end

			am_lock_pkg::LOCKED:
			begin
				if (timer_done && lane_hit)
				begin
					am_pos = 1'b1;
					bad_d = '0;
				end
				else if (timer_done)
				begin
					bad_d = bad_inc;
					if (bad_inc >= i_unlock_thr)
					begin
						mask_d = '1;
						state_d = am_lock_pkg::WAIT_1ST;
					end
				end
			end

			default:
			begin
				state_d = am_lock_pkg::INIT;
			end
		endcase
	end

	// lock decision rides with the block that made it
	always_comb
	begin
		ctl_d.lock = (state_d == am_lock_pkg::LOCKED);
		ctl_d.am_pos = am_pos;
		ctl_d.mask = mask_d;
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q <= am_lock_pkg::INIT;
			mask_q <= '1;
			timer_q <= '0;
			good_q <= '0;
			bad_q <= '0;
			ctl_q <= '0;
		end
		else if (!i_block_lock)
		begin
			state_q <= am_lock_pkg::INIT;
			mask_q <= '1;
			good_q <= '0;
			bad_q <= '0;
			ctl_q <= '0;
		end
		else if (i_result.strm.valid)
		begin
			state_q <= state_d;
			mask_q <= mask_d;
			timer_q <= timer_d;
			good_q <= good_d;
			bad_q <= bad_d;
			ctl_q <= ctl_d;
		end
		else
		begin
			ctl_q.am_pos <= 1'b0;	// bubbles carry no marker
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
			blk_valid_q <= 1'b0;
		else
			blk_valid_q <= i_result.strm.valid;
	end

	always_ff @(posedge i_clock)
	begin
		blk_q <= i_result.strm.blk;
	end

	assign o_block.valid = blk_valid_q;
	assign o_block.blk = blk_q;
	assign o_ctl = ctl_q;

	// lock only comes from a confirmed marker in WAIT_2ND
	a_lock_from_confirm: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		$rose(ctl_q.lock) |-> ($past(state_q) == am_lock_pkg::WAIT_2ND) && ctl_q.am_pos
	);

	// one lane captured once the first marker is seen
	a_mask_onehot: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		(state_q inside {am_lock_pkg::WAIT_2ND, am_lock_pkg::LOCKED}) |-> $onehot(mask_q)
	);

endmodule

`default_nettype wire

/* design/am_compare.sv */
`default_nettype none

`include "am_lock_cfg.svh"

module am_compare
(
	input wire logic i_clock,
	input wire logic i_arst_n,
	input wire am_lock_pkg::blk_stream_s i_block,
	output am_lock_pkg::am_result_s o_result
);

	localparam am_lock_pkg::payload_t PATTERNS [`AM_N_LANES] = '{
		`AM_PATTERN_0,
		`AM_PATTERN_1,
		`AM_PATTERN_2,
		`AM_PATTERN_3
	};

	am_lock_pkg::lane_mask_t match_d;
	logic is_ctrl;

	logic valid_q;
	logic is_am_q;
	am_lock_pkg::lane_mask_t match_q;
	am_lock_pkg::block_t blk_q;

	// markers only ever come with a control header
	assign is_ctrl = (i_block.blk.sync == `AM_SYNC_CTRL);

	for (genvar g = 0; g < `AM_N_LANES; g++)
	begin : g_match
		assign match_d[g] = i_block.valid && is_ctrl
			&& (i_block.blk.payload == PATTERNS[g]);
	end

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			valid_q <= 1'b0;
			is_am_q <= 1'b0;
			match_q <= '0;
		end
		else
		begin
			valid_q <= i_block.valid;
			is_am_q <= |match_d;
			match_q <= match_d;
		end
	end

	// payload path
	always_ff @(posedge i_clock)
	begin
		blk_q <= i_block.blk;
	end

	assign o_result.strm.valid = valid_q;
	assign o_result.strm.blk = blk_q;
	assign o_result.is_am = is_am_q;
	assign o_result.match = match_q;

	// the pattern table has no two equal entries
	a_match_onehot0: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		$onehot0(match_q)
	);

endmodule

`default_nettype wire

/* design/am_lock_pkg.sv */
`default_nettype none

`include "am_lock_cfg.svh"

package am_lock_pkg;

	typedef logic [1:0] sync_t;
	typedef logic [63:0] payload_t;
	typedef logic [`AM_N_LANES-1:0] lane_mask_t;
	typedef logic [1:0] lane_idx_t;
	typedef logic [`AM_THR_W-1:0] thr_t;
	typedef logic [4:0] spacing_cnt_t;	// must hold AM_SPACING
	typedef logic [31:0] wb_data_t;

	typedef struct packed {
		sync_t sync;
		payload_t payload;
	} block_t;

	typedef struct packed {
		logic valid;
		block_t blk;
	} blk_stream_s;

	// stage 1 output
	typedef struct packed {
		blk_stream_s strm;
		logic is_am;
		lane_mask_t match;	// one bit per pattern
	} am_result_s;

	typedef enum logic [1:0] {
		INIT,
		WAIT_1ST,
		WAIT_2ND,
		LOCKED
	} lock_state_e;

	// travels with the block out of stage 2
	typedef struct packed {
		logic lock;
		logic am_pos;	// confirmed marker at expected position
		lane_mask_t mask;
	} lock_ctl_s;

endpackage

`default_nettype wire

/* include/am_lock_cfg.svh */
`ifndef AM_LOCK_CFG_SVH
`define AM_LOCK_CFG_SVH

// lane count and marker period, small for simulation
`define AM_N_LANES 4
`define AM_SPACING 16

// threshold and counter width
`define AM_THR_W 4
`define AM_LOCK_THR_RST 3
`define AM_UNLOCK_THR_RST 2

// 66b sync headers
`define AM_SYNC_CTRL 2'b10
`define AM_SYNC_DATA 2'b01

// marker payloads as M0 M1 M2 BIP3 M4 M5 M6 BIP7, BIP bytes held at zero
`define AM_PATTERN_0 64'hC168_2100_3E97_DE00
`define AM_PATTERN_1 64'h9D71_8E00_628E_7100
`define AM_PATTERN_2 64'h594B_E800_A6B4_1700
`define AM_PATTERN_3 64'h4D95_7B00_B26A_8400

// wishbone word addresses
`define AM_WB_ADR_W 2
`define AM_REG_LOCK_THR 2'd0
`define AM_REG_UNLOCK_THR 2'd1
`define AM_REG_STATUS 2'd2

`endif
